//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= project.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hw/alu_core.sv
`default_nettype none

module alu_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,        // issue strobe
    input  alu_pkg::alu_cmd_t   cmd,
    input  logic [31:0]         op0,        // destination value
    input  logic [31:0]         op1,        // source value
    input  alu_pkg::imm_word_u  imm,
    output alu_pkg::flags_t     flags,
    output alu_pkg::width_t     alu_we,
    output logic [31:0]         dout
);
    import alu_pkg::*;

    logic [31:0] op2;                       // effective source
    logic [31:0] rslt;
    logic [32:0] ext_rslt;                  // sign-extended sum for V
    logic [7:0]  nib_c;                     // carry out of each nibble
    logic        carry;
    logic        cin;
    logic        is_sub;
    logic [3:0]  bs_idx;
    logic [15:0] step;
    flags_t      nx;

    function automatic logic [32:0] sext(input logic [31:0] x, input width_t w);
        if (w[0]) begin
            return {{25{x[7]}}, x[7:0]};
        end
        if (w[1]) begin
            return {{17{x[15]}}, x[15:0]};
        end
        return {x[31], x};
    endfunction

    function automatic logic w_msb(input logic [31:0] x, input width_t w);
        return w[0] ? x[7] : w[1] ? x[15] : x[31];
    endfunction

    function automatic logic w_zero(input logic [31:0] x, input width_t w);
        return w[0] ? (x[7:0] == 8'd0) : w[1] ? (x[15:0] == 16'd0) : (x == 32'd0);
    endfunction

    function automatic logic w_even(input logic [31:0] x, input width_t w);
        return w[0] ? ~^x[7:0] : w[1] ? ~^x[15:0] : ~^x;
    endfunction

    assign op2 = cmd.sel_imm ? imm.data : op1;

    always_comb begin
        nx       = flags;                   // sticky unless the op says otherwise
        rslt     = dout;
        ext_rslt = '0;
        nib_c    = '0;
        carry    = 1'b0;
        cin      = 1'b0;
        is_sub   = 1'b0;
        bs_idx   = 4'd0;
        step     = 16'd0;

        case (cmd.op)
            ALU_MOVE: rslt = op2;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC: begin
                is_sub = (cmd.op == ALU_SUB) || (cmd.op == ALU_SBC);
                cin    = ((cmd.op == ALU_ADC) || (cmd.op == ALU_SBC)) ? flags.c : 1'b0;
                carry  = cin;
                // ripple nibble by nibble, top bit is carry or borrow
                for (int k = 0; k < 8; k++) begin
                    if (is_sub) begin
                        {carry, rslt[4*k +: 4]} = {1'b0, op0[4*k +: 4]}
                                                - {1'b0, op2[4*k +: 4]} - {4'd0, carry};
                    end else begin
                        {carry, rslt[4*k +: 4]} = {1'b0, op0[4*k +: 4]}
                                                + {1'b0, op2[4*k +: 4]} + {4'd0, carry};
                    end
                    nib_c[k] = carry;
                end
                if (is_sub) begin
                    ext_rslt = sext(op0, cmd.w) - sext(op2, cmd.w) - {32'd0, cin};
                end else begin
                    ext_rslt = sext(op0, cmd.w) + sext(op2, cmd.w) + {32'd0, cin};
                end
                nx.s = w_msb(rslt, cmd.w);
                nx.z = w_zero(rslt, cmd.w);
                nx.h = nib_c[0];
                nx.v = ext_rslt[32] ^ w_msb(rslt, cmd.w);   // true sign vs kept sign
                nx.n = is_sub;
                nx.c = cmd.w[0] ? nib_c[1] : cmd.w[1] ? nib_c[3] : nib_c[7];
            end
            ALU_AND, ALU_OR: begin
                rslt = (cmd.op == ALU_AND) ? (op0 & op2) : (op0 | op2);
                nx.s = w_msb(rslt, cmd.w);
                nx.z = w_zero(rslt, cmd.w);
                nx.h = (cmd.op == ALU_AND);
                nx.v = w_even(rslt, cmd.w);  // parity, even -> 1
                nx.n = 1'b0;
                nx.c = 1'b0;
            end
            ALU_MDEC1, ALU_MDEC2, ALU_MDEC4: begin
                step = (cmd.op == ALU_MDEC1) ? 16'd1 :
                       (cmd.op == ALU_MDEC2) ? 16'd2 : 16'd4;
                // wrap to the top of the modulo window on boundary
                if ((op0[15:0] & op2[15:0]) == 16'd0) begin
                    rslt[15:0] = op0[15:0] + op2[15:0];
                end else begin
                    rslt[15:0] = op0[15:0] - step;
                end
            end
            ALU_BIT: begin
                nx.z = ~op1[imm.bitsel.bit_idx];
                nx.h = 1'b1;
                nx.n = 1'b0;
            end
            ALU_BITX: begin
                nx.z = ~imm.data[imm.bitsel.bitx_idx];
                nx.h = 1'b1;
                nx.n = 1'b0;
            end
            ALU_BS1F: begin
                for (int k = 15; k >= 0; k--) begin
                    if (op1[k]) begin
                        bs_idx = 4'(k);     // last hit is the lowest one
                    end
                end
                rslt = {28'd0, bs_idx};
                nx.v = (op1[15:0] == 16'd0);
            end
            ALU_BS1B: begin
                for (int k = 0; k < 16; k++) begin
                    if (op1[k]) begin
                        bs_idx = 4'(k);     // last hit is the highest one
                    end
                end
                rslt = {28'd0, bs_idx};
                nx.v = (op1[15:0] == 16'd0);
            end
            ALU_CCF: begin
                nx.c = ~flags.c;
                nx.n = 1'b0;
            end
            default: ;
        endcase

        nx.zero5 = 1'b0;
        nx.zero3 = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flags  <= '0;
            alu_we <= W_NONE;
        end else begin
            alu_we <= cen ? cmd.w : W_NONE;         // one write-back cycle per issue
            if (cen && cmd.w != W_NONE) begin
                dout <= rslt;
            end
            if (cen && (cmd.w != W_NONE || cmd.flag_we)) begin
                flags <= nx;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_gpr.sv
`default_nettype none

module alu_gpr #(
    parameter int NUM_GPR = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          rd_a_idx,
    input  logic [3:0]          rd_b_idx,
    input  logic [3:0]          rd_host_idx,
    output logic [31:0]         rd_a,
    output logic [31:0]         rd_b,
    output logic [31:0]         rd_host,
    input  alu_pkg::width_t     alu_we,
    input  logic [3:0]          alu_idx,
    input  logic [31:0]         alu_wdata,
    input  logic                host_we,
    input  logic [3:0]          host_idx,
    input  logic [31:0]         host_wdata
);
    import alu_pkg::*;

    localparam int IW = (NUM_GPR > 1) ? $clog2(NUM_GPR) : 1;

    logic [31:0] bank [NUM_GPR];

    // async read ports, upper index bits alias
    assign rd_a    = bank[rd_a_idx[IW-1:0]];
    assign rd_b    = bank[rd_b_idx[IW-1:0]];
    assign rd_host = bank[rd_host_idx[IW-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                bank[i] <= '0;
            end
        end else begin
            if (alu_we == W_LONG) begin
                bank[alu_idx[IW-1:0]] <= alu_wdata;
            end else if (alu_we == W_WORD) begin
                bank[alu_idx[IW-1:0]][15:0] <= alu_wdata[15:0];    // keep upper half
            end else if (alu_we == W_BYTE) begin
                bank[alu_idx[IW-1:0]][7:0] <= alu_wdata[7:0];      // keep upper bytes
            end
            if (host_we) begin
                bank[host_idx[IW-1:0]] <= host_wdata;  // host stalled while busy
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // operation select, codes outside this list leave result and flags alone
    typedef enum logic [5:0] {
        ALU_MOVE  = 6'd0,
        ALU_ADD   = 6'd1,
        ALU_ADC   = 6'd2,
        ALU_SUB   = 6'd3,
        ALU_SBC   = 6'd4,
        ALU_AND   = 6'd5,
        ALU_OR    = 6'd6,
        ALU_MDEC1 = 6'd7,
        ALU_MDEC2 = 6'd8,
        ALU_MDEC4 = 6'd9,
        ALU_BIT   = 6'd10,
        ALU_BITX  = 6'd11,
        ALU_BS1F  = 6'd12,
        ALU_BS1B  = 6'd13,
        ALU_CCF   = 6'd14
    } alu_op_e;

    typedef logic [2:0] width_t;            // one-hot, 0 = flags only
    localparam width_t W_NONE = 3'b000;
    localparam width_t W_BYTE = 3'b001;
    localparam width_t W_WORD = 3'b010;
    localparam width_t W_LONG = 3'b100;

    typedef struct packed {
        logic s;
        logic z;
        logic zero5;                        // always 0
        logic h;
        logic zero3;                        // always 0
        logic v;                            // overflow or parity
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic [2:0]  bitx_idx;              // bit tested in the immediate itself
        logic [4:0]  rsvd_mid;
        logic [3:0]  bit_idx;               // bit tested in op1
    } imm_bitsel_t;

    // same 32 bits seen as data or as bit select fields
    typedef union packed {
        logic [31:0] data;
        imm_bitsel_t bitsel;
    } imm_word_u;

    // CMD register image, bits 22..0
    typedef struct packed {
        alu_op_e    op;                     // 22:17
        width_t     w;                      // 16:14
        logic       sel_imm;                // 13
        logic       flag_we;                // 12
        logic [3:0] rsvd;                   // 11:8, ignored
        logic [3:0] dst;                    // 7:4
        logic [3:0] src;                    // 3:0
    } alu_cmd_t;

    localparam logic [7:0] REG_CMD      = 8'h00;
    localparam logic [7:0] REG_IMM      = 8'h04;
    localparam logic [7:0] REG_FLAGS    = 8'h08;
    localparam logic [7:0] REG_STATUS   = 8'h0C;
    localparam logic [7:0] REG_GPR_BASE = 8'h20;   // one word per bank reg

endpackage

`default_nettype wire

//--- hw/alu_regs.sv
`default_nettype none

module alu_regs #(
    parameter int NUM_GPR = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [7:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    output alu_pkg::alu_cmd_t   cmd,
    output alu_pkg::imm_word_u  imm,
    output logic                issue,
    input  alu_pkg::flags_t     flags,
    output logic                host_we,
    output logic [3:0]          host_idx,
    output logic [31:0]         host_wdata,
    input  logic [31:0]         rd_host
);
    import alu_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ARM, S_ISSUE, S_WBACK} seq_e;

    seq_e        seq;
    logic        busy;
    logic        wr_fire;
    logic        ar_fire;
    logic [31:0] cmd_merged;
    logic [31:0] rd_word;

    function automatic logic in_gpr(input logic [7:0] a);
        logic [7:0] off;
        off = a - REG_GPR_BASE;
        return (a >= REG_GPR_BASE) && (off[7:2] < NUM_GPR);
    endfunction

    function automatic logic [3:0] gpr_idx(input logic [7:0] a);
        logic [7:0] off;
        off = a - REG_GPR_BASE;
        return off[5:2];
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] cur, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = strb[i] ? nw[8*i +: 8] : cur[8*i +: 8];
        end
        return r;
    endfunction

    assign busy    = (seq != S_IDLE);
    // aw and w taken together, none while busy or a response is pending
    assign wr_fire = awvalid && wvalid && !bvalid && !busy;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = !rvalid && !wr_fire;  // bank port shared with writes
    assign ar_fire = arvalid && arready;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    assign host_idx   = wr_fire ? gpr_idx(awaddr) : gpr_idx(araddr);
    assign host_we    = wr_fire && in_gpr(awaddr);
    assign host_wdata = merge(rd_host, wdata, wstrb);     // rd_host = old word here
    assign cmd_merged = merge({{(32 - $bits(alu_cmd_t)){1'b0}}, cmd}, wdata, wstrb);

    always_comb begin
        rd_word = '0;                      // unmapped reads zero
        case (araddr)
            REG_CMD:    rd_word = {{(32 - $bits(alu_cmd_t)){1'b0}}, cmd};
            REG_IMM:    rd_word = imm.data;
            REG_FLAGS:  rd_word = {24'd0, flags};
            REG_STATUS: rd_word = {31'd0, busy};
            default: begin
                if (in_gpr(araddr)) begin
                    rd_word = rd_host;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_fire && awaddr == REG_IMM) begin
            imm.data <= merge(imm.data, wdata, wstrb);
        end
        if (ar_fire) begin
            rdata <= rd_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd    <= '0;
            seq    <= S_IDLE;
            issue  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            issue <= (seq == S_ARM);      // core samples during S_ISSUE
            case (seq)
                S_IDLE: begin
                    if (wr_fire && awaddr == REG_CMD) begin
                        cmd <= alu_cmd_t'(cmd_merged[$bits(alu_cmd_t)-1:0]);
                        seq <= S_ARM;
                    end
                end
                S_ARM:   seq <= S_ISSUE;   // operands read at new dst/src
                S_ISSUE: seq <= S_WBACK;
                S_WBACK: seq <= S_IDLE;    // bank written on this edge
                default: seq <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_top.sv
`default_nettype none

module alu_top #(
    parameter int NUM_GPR = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import alu_pkg::*;

    alu_cmd_t    cmd;
    imm_word_u   imm;
    flags_t      flags;
    width_t      alu_we;
    logic        issue;
    logic        host_we;
    logic [3:0]  host_idx;
    logic [31:0] host_wdata;
    logic [31:0] rd_host;
    logic [31:0] op0;                      // bank[dst]
    logic [31:0] op1;                      // bank[src]
    logic [31:0] dout;

    alu_regs #(.NUM_GPR(NUM_GPR)) i_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cmd(cmd), .imm(imm), .issue(issue), .flags(flags),
        .host_we(host_we), .host_idx(host_idx), .host_wdata(host_wdata),
        .rd_host(rd_host)
    );

    alu_gpr #(.NUM_GPR(NUM_GPR)) i_gpr (
        .clk(clk), .rst(rst),
        .rd_a_idx(cmd.dst), .rd_b_idx(cmd.src), .rd_host_idx(host_idx),
        .rd_a(op0), .rd_b(op1), .rd_host(rd_host),
        .alu_we(alu_we), .alu_idx(cmd.dst), .alu_wdata(dout),  // write-back to dst
        .host_we(host_we), .host_idx(host_idx), .host_wdata(host_wdata)
    );

    alu_core i_core (
        .clk(clk), .rst(rst), .cen(issue),
        .cmd(cmd), .op0(op0), .op1(op1), .imm(imm),
        .flags(flags), .alu_we(alu_we), .dout(dout)
    );

endmodule

`default_nettype wire

//--- project.f
hw/alu_pkg.sv
hw/alu_core.sv
hw/alu_gpr.sv
hw/alu_regs.sv
hw/alu_top.sv
tests/alu_tb.sv
tests/alu_tb_sva.sv

//--- tests/alu_tb.sv
`default_nettype none

module alu_tb;
    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [7:0]  awaddr = '0;
    logic        awvalid = 1'b0;
    logic        awready;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = 4'hF;
    logic        wvalid = 1'b0;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready = 1'b0;
    logic [7:0]  araddr = '0;
    logic        arvalid = 1'b0;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready = 1'b0;

    integer      seed = 32'h26b4;
    integer      errors = 0;
    integer      tests = 0;
    integer      t_err;                     // errors at start of current test
    logic [31:0] exp_gpr [8];               // model of the bank
    logic [7:0]  exp_flags;                 // S Z 0 H 0 V N C

    alu_top #(.NUM_GPR(8)) i_dut (.*);

    always #4 clk = ~clk;

    task automatic give_up(input string what);
        $display("timeout waiting for %s at %0t", what, $time);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got) else begin
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [7:0] a, input logic [31:0] d);
        integer n;
        awaddr = a;
        wdata = d;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin  // stalls while busy
            n = n + 1;
            if (n > 100) give_up("awready");
            @(negedge clk);
        end
        @(posedge clk);
        #1 awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n = n + 1;
            if (n > 100) give_up("bvalid");
            @(negedge clk);
        end
        check("bresp", 32'd0, {30'd0, bresp});
        @(posedge clk);
        #1 bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] a, output logic [31:0] d);
        integer n;
        araddr = a;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n = n + 1;
            if (n > 100) give_up("arready");
            @(negedge clk);
        end
        @(posedge clk);
        #1 arvalid = 1'b0;
        rready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n = n + 1;
            if (n > 100) give_up("rvalid");
            @(negedge clk);
        end
        d = rdata;                          // stable mid-cycle
        check("rresp", 32'd0, {30'd0, rresp});
        @(posedge clk);
        #1 rready = 1'b0;
    endtask

    task automatic set_reg(input integer i, input logic [31:0] v);
        axi_write(8'h20 + 8'(4 * i), v);
        exp_gpr[i] = v;
    endtask

    // expected result and flags straight from the operation rules
    task automatic model(input logic [5:0] op, input logic [2:0] w, input logic sel,
                         input logic fwe, input integer dst, input integer src,
                         input logic [31:0] immv);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        logic [31:0] res;
        logic [63:0] full;
        logic [4:0]  hn;
        logic [7:0]  f;
        logic        cin;
        logic        sub;
        logic        sa;
        logic        sb;
        logic        sr;
        integer      nb;
        a = exp_gpr[dst];
        b = sel ? immv : exp_gpr[src];
        f = exp_flags;
        res = '0;
        nb = w[0] ? 8 : w[1] ? 16 : 32;
        m = (nb == 32) ? 32'hFFFF_FFFF : ((32'd1 << nb) - 32'd1);
        case (op)
            6'd0: res = b;                                  // move, flags kept
            6'd1, 6'd2, 6'd3, 6'd4: begin
                cin = (op == 6'd2 || op == 6'd4) && f[0];
                sub = (op >= 6'd3);
                if (sub) begin
                    full = {32'd0, a & m} - {32'd0, b & m} - {63'd0, cin};
                    hn = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
                end else begin
                    full = {32'd0, a & m} + {32'd0, b & m} + {63'd0, cin};
                    hn = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
                end
                res = full[31:0] & m;
                sa = a[nb-1];
                sb = b[nb-1];
                sr = res[nb-1];
                f[7] = sr;
                f[6] = (res == 0);
                f[4] = hn[4];                               // nibble carry or borrow
                f[2] = sub ? (sa != sb && sr != sa) : (sa == sb && sr != sa);
                f[1] = sub;
                f[0] = full[nb];
            end
            6'd5, 6'd6: begin
                res = ((op == 6'd5) ? (a & b) : (a | b)) & m;
                f[7] = res[nb-1];
                f[6] = (res == 0);
                f[4] = (op == 6'd5);
                f[2] = ~^res;                               // even parity
                f[1] = 1'b0;
                f[0] = 1'b0;
            end
            6'd7, 6'd8, 6'd9: begin
                if ((a[15:0] & b[15:0]) == 16'd0) res[15:0] = a[15:0] + b[15:0];
                else res[15:0] = a[15:0] - ((op == 6'd7) ? 16'd1 : (op == 6'd8) ? 16'd2 : 16'd4);
            end
            6'd10: begin
                f[6] = ~exp_gpr[src][immv[3:0]];
                f[4] = 1'b1;
                f[1] = 1'b0;
            end
            6'd11: begin
                f[6] = ~immv[immv[11:9]];
                f[4] = 1'b1;
                f[1] = 1'b0;
            end
            6'd12, 6'd13: begin
                for (int i = 0; i < 16; i++) begin
                    if (exp_gpr[src][i] && (op == 6'd13 || res == 0 && !exp_gpr[src][res]))
                        res = i;                            // first hit from the low end for BS1F
                end
                f[2] = (exp_gpr[src][15:0] == 16'd0);
            end
            6'd14: begin
                f[0] = ~f[0];
                f[1] = 1'b0;
            end
            default: ;
        endcase
        if (w != 3'd0) exp_gpr[dst] = (a & ~m) | (res & m);
        if (w != 3'd0 || fwe) exp_flags = f;
    endtask

    task automatic run_cmd(input logic [5:0] op, input logic [2:0] w, input logic sel,
                           input logic fwe, input integer dst, input integer src,
                           input logic [31:0] immv);
        logic [31:0] d;
        integer      n;
        model(op, w, sel, fwe, dst, src, immv);
        axi_write(8'h04, immv);
        axi_write(8'h00, {9'd0, op, w, sel, fwe, 4'd0, 4'(dst), 4'(src)});
        n = 0;
        d = 32'd1;
        while (d[0]) begin                  // poll STATUS.busy
            n = n + 1;
            if (n > 50) give_up("command done");
            axi_read(8'h0C, d);
        end
        axi_read(8'h20 + 8'(4 * dst), d);
        check("dst_reg", exp_gpr[dst], d);
        axi_read(8'h08, d);
        check("flags", {24'd0, exp_flags}, d);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - t_err);
        t_err = errors;
    endtask

    initial begin
        logic [31:0] d;
        logic [2:0]  ws [3];
        ws[0] = 3'b001;
        ws[1] = 3'b010;
        ws[2] = 3'b100;
        for (int i = 0; i < 8; i++) exp_gpr[i] = '0;
        exp_flags = '0;
        t_err = 0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        axi_read(8'h08, d);
        check("flags", 32'd0, d);
        axi_read(8'h0C, d);
        check("status", 32'd0, d);
        for (int i = 0; i < 8; i++) begin
            axi_read(8'h20 + 8'(4 * i), d);
            check("bank_reset", 32'd0, d);
        end
        end_test("reset values");

        for (int k = 0; k < 12; k++) begin
            set_reg(1, $random(seed));
            set_reg(2, $random(seed));
            run_cmd(6'd1, ws[k % 3], 1'b0, 1'b0, 1, 2, '0);   // add
            run_cmd(6'd2, ws[k % 3], 1'b0, 1'b0, 1, 2, '0);   // adc chains c
        end
        end_test("add adc");

        for (int k = 0; k < 3; k++) begin
            run_cmd(6'd0, 3'b100, 1'b1, 1'b0, 3, 0, 32'h0000_0080 << ((k == 2) ? 24 : 8 * k));
            run_cmd(6'd0, 3'b100, 1'b1, 1'b0, 4, 0, 32'd1);
            run_cmd(6'd3, ws[k], 1'b0, 1'b0, 3, 4, '0);       // signed overflow
            run_cmd(6'd0, 3'b100, 1'b1, 1'b0, 3, 0, 32'd0);
            run_cmd(6'd3, ws[k], 1'b0, 1'b0, 3, 4, '0);       // borrow
            run_cmd(6'd4, ws[k], 1'b0, 1'b0, 3, 4, '0);
            set_reg(5, $random(seed));
            run_cmd(6'd4, ws[k], 1'b1, 1'b0, 5, 0, $random(seed));
        end
        end_test("sub sbc move");

        for (int k = 0; k < 9; k++) begin
            set_reg(1, $random(seed));
            set_reg(2, $random(seed));
            run_cmd((k & 1) ? 6'd6 : 6'd5, ws[k % 3], 1'b0, 1'b0, 1, 2, '0);
        end
        end_test("and or");

        for (int k = 0; k < 6; k++) begin
            set_reg(6, $random(seed));
            run_cmd(6'd10, 3'b000, 1'b0, 1'b1, 1, 6, $random(seed));
            run_cmd(6'd11, 3'b000, 1'b0, 1'b1, 1, 6, $random(seed));
            run_cmd(6'd14, 3'b000, 1'b0, 1'b1, 1, 6, '0);
        end
        for (int i = 0; i < 8; i++) begin
            axi_read(8'h20 + 8'(4 * i), d);
            check("bank_kept", exp_gpr[i], d);
        end
        end_test("bit bitx ccf");

        for (int k = 0; k < 6; k++) begin
            set_reg(2, (k == 5) ? 32'd0 : $random(seed) & 32'h0000_FFFF);
            run_cmd(6'd12, 3'b010, 1'b0, 1'b0, 1, 2, '0);
            run_cmd(6'd13, 3'b010, 1'b0, 1'b0, 1, 2, '0);
            set_reg(3, $random(seed));
            run_cmd(6'd7 + 6'(k % 3), 3'b010, 1'b1, 1'b0, 3, 0, 32'h0000_0100 << (k % 3));
        end
        end_test("bs1f bs1b mdec");

        set_reg(2, 32'h0000_1234);
        set_reg(7, 32'h0000_1111);
        model(6'd1, 3'b100, 1'b0, 1'b0, 2, 7, '0);
        axi_write(8'h00, {9'd0, 6'd1, 3'b100, 2'b00, 4'd0, 4'd2, 4'd7});
        set_reg(5, 32'hCAFE_0005);          // stalls behind the add
        axi_read(8'h28, d);
        check("dst_reg", exp_gpr[2], d);
        axi_read(8'h34, d);
        check("host_reg", exp_gpr[5], d);
        end_test("host write stall");

        if (errors == 0) begin
            $display("%0d tests, 0 errors", tests);
            $display("TEST OK");
        end else begin
            $display("%0d tests, %0d errors", tests, errors);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/alu_tb_sva.sv
`default_nettype none

module alu_tb_sva (
    input wire       clk,
    input wire       rst,
    input wire       bvalid,
    input wire       bready,
    input wire       rvalid,
    input wire       rready,
    input wire       awready,
    input wire       busy,
    input wire [2:0] alu_we,
    input wire [7:0] flags
);

    // responses held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped");
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped");

    a_no_aw_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !awready) else $error("awready while busy");

    // arm, issue, write-back
    a_busy_len: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |=> busy ##1 busy ##1 !busy) else $error("busy length");

    a_flag_pad: assert property (@(posedge clk) disable iff (rst)
        !flags[5] && !flags[3]) else $error("flag padding set");

    // write-back is the last busy cycle
    a_we_wback: assert property (@(posedge clk) disable iff (rst)
        alu_we != 3'd0 |-> busy ##1 !busy) else $error("alu_we outside write-back");

endmodule

bind alu_top alu_tb_sva i_sva (
    .clk(clk), .rst(rst), .bvalid(bvalid), .bready(bready), .rvalid(rvalid),
    .rready(rready), .awready(awready), .busy(i_regs.busy),
    .alu_we(alu_we), .flags(flags)
);

`default_nettype wire
